// File: Bender.yml
package:
  name: snoop_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/snoop_pkg.sv
      - common/snoop_if.sv
      - snoop/snoop_unit.sv
      - logic/l1d_array.sv
      - logic/store_queue.sv
      - logic/snoop_subsys_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/snoop_assert.sv
      - sim/snoop_tb.sv

// File: common/snoop_defines.svh
// Size macros for the snoop subsystem
// Include wherever address, line, cache or queue geometry is needed

`ifndef SNOOP_DEFINES_SVH
`define SNOOP_DEFINES_SVH

// Physical address and line
`define SNOOP_PADDR_W   32
`define SNOOP_LINE_B    16
`define SNOOP_LINE_W    128
`define SNOOP_OFFSET_W  4

// L1D geometry
`define SNOOP_L1D_SETS  8
`define SNOOP_INDEX_W   3
`define SNOOP_L1D_WAYS  2

`define SNOOP_STQ_DEPTH 4           // Store queue entries

`endif

// File: common/snoop_if.sv
// Internal broadcast interfaces between the snoop unit and its responders
// Requests are single-cycle pulses, responses follow one cycle later

`default_nettype none

`include "snoop_defines.svh"

interface l1d_snoop_if;
    logic                       req_valid;
    snoop_pkg::snoop_cmd_t      req_cmd;
    snoop_pkg::paddr_u          req_paddr;
    logic [`SNOOP_L1D_WAYS-1:0] req_ways;     // Way to invalidate
    logic                       resp_valid;
    snoop_pkg::snoop_status_t   resp_status;
    logic [`SNOOP_L1D_WAYS-1:0] resp_ways;    // Hit way, one-hot
    snoop_pkg::line_t           resp_data;

    modport unit (
        output req_valid, req_cmd, req_paddr, req_ways,
        input  resp_valid, resp_status, resp_ways, resp_data
    );

    modport array (
        input  req_valid, req_cmd, req_paddr, req_ways,
        output resp_valid, resp_status, resp_ways, resp_data
    );
endinterface

interface stq_snoop_if;
    logic                   req_valid;
    snoop_pkg::paddr_u      req_paddr;
    logic                   resp_valid;
    snoop_pkg::line_t       resp_data;
    snoop_pkg::line_be_t    resp_be;

    modport unit (
        output req_valid, req_paddr,
        input  resp_valid, resp_data, resp_be
    );

    modport queue (
        input  req_valid, req_paddr,
        output resp_valid, resp_data, resp_be
    );
endinterface

`default_nettype wire

// File: common/snoop_pkg.sv
// Shared types of the snoop subsystem
// Commands, responder status and the physical address union

`default_nettype none

`include "snoop_defines.svh"

package snoop_pkg;

    typedef enum logic {
        snoop_read,
        snoop_invalid
    } snoop_cmd_t;

    typedef enum logic [1:0] {
        status_hit,
        status_miss,
        status_conflict             // Array busy with a fill
    } snoop_status_t;

    typedef struct packed {
        logic [`SNOOP_PADDR_W-`SNOOP_INDEX_W-`SNOOP_OFFSET_W-1:0] tag;
        logic [`SNOOP_INDEX_W-1:0]                               index;
        logic [`SNOOP_OFFSET_W-1:0]                              offset;
    } paddr_fields_t;

    // Flat word for line compares, fields for the L1D decode
    typedef union packed {
        logic [`SNOOP_PADDR_W-1:0] word;
        paddr_fields_t             fields;
    } paddr_u;

    typedef logic [`SNOOP_LINE_W-1:0] line_t;
    typedef logic [`SNOOP_LINE_B-1:0] line_be_t;

endpackage

`default_nettype wire

// File: compile.f
+incdir+common
common/snoop_pkg.sv
common/snoop_if.sv
snoop/snoop_unit.sv
logic/l1d_array.sv
logic/store_queue.sv
logic/snoop_subsys_top.sv
sim/snoop_assert.sv
sim/snoop_tb.sv

// File: logic/l1d_array.sv
// Two-way L1 data array with a core fill port and a snoop port
// Snoop reads and invalidates answer one cycle later, and report a
// conflict when a fill used the array in the request cycle

`default_nettype none

`include "snoop_defines.svh"

module l1d_array (
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire                     fill_valid,
    input  wire snoop_pkg::paddr_u  fill_paddr,
    input  wire snoop_pkg::line_t   fill_data,
    l1d_snoop_if.array              snoop
);

    localparam int TAG_W = `SNOOP_PADDR_W - `SNOOP_INDEX_W - `SNOOP_OFFSET_W;
    localparam int WAY_W = $clog2(`SNOOP_L1D_WAYS);

    logic [TAG_W-1:0]           tag_q   [`SNOOP_L1D_SETS][`SNOOP_L1D_WAYS];
    snoop_pkg::line_t           data_q  [`SNOOP_L1D_SETS][`SNOOP_L1D_WAYS];
    logic [`SNOOP_L1D_WAYS-1:0] valid_q [`SNOOP_L1D_SETS];
    logic [`SNOOP_L1D_SETS-1:0] rr_q;                   // Replacement way per set

    logic [`SNOOP_INDEX_W-1:0]  fill_idx;
    logic [`SNOOP_INDEX_W-1:0]  snp_idx;
    logic [`SNOOP_L1D_WAYS-1:0] fill_hit_ways;
    logic [`SNOOP_L1D_WAYS-1:0] snp_hit_ways;
    logic [WAY_W-1:0]           fill_way;
    snoop_pkg::line_t           snp_data;

    assign fill_idx = fill_paddr.fields.index;
    assign snp_idx  = snoop.req_paddr.fields.index;

    // Tag compare for both ports
    always_comb begin
        fill_way = WAY_W'(rr_q[fill_idx]);
        snp_data = '0;
        for (int w = 0; w < `SNOOP_L1D_WAYS; w++) begin
            fill_hit_ways[w] = valid_q[fill_idx][w] &&
                               (tag_q[fill_idx][w] == fill_paddr.fields.tag);
            snp_hit_ways[w]  = valid_q[snp_idx][w] &&
                               (tag_q[snp_idx][w] == snoop.req_paddr.fields.tag);
            if (fill_hit_ways[w]) begin
                fill_way = WAY_W'(w);                   // Refill in place
            end
            if (snp_hit_ways[w]) begin
                snp_data = data_q[snp_idx][w];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            valid_q          <= '{default: '0};
            rr_q             <= '0;
            snoop.resp_valid <= 1'b0;
        end else begin
            snoop.resp_valid <= snoop.req_valid;
            if (fill_valid) begin
                valid_q[fill_idx][fill_way] <= 1'b1;
                if (fill_hit_ways == '0) begin
                    rr_q[fill_idx] <= ~rr_q[fill_idx];
                end
            end else if (snoop.req_valid && snoop.req_cmd == snoop_pkg::snoop_invalid) begin
                valid_q[snp_idx] <= valid_q[snp_idx] & ~snoop.req_ways;
            end
        end
    end

    // Line storage and response payload
    always_ff @(posedge i_clk) begin
        if (fill_valid) begin
            tag_q[fill_idx][fill_way]  <= fill_paddr.fields.tag;
            data_q[fill_idx][fill_way] <= fill_data;
        end
        if (snoop.req_valid) begin
            snoop.resp_ways <= snp_hit_ways;
            snoop.resp_data <= snp_data;
            if (fill_valid) begin
                snoop.resp_status <= snoop_pkg::status_conflict;
            end else if (snoop.req_cmd == snoop_pkg::snoop_invalid || |snp_hit_ways) begin
                snoop.resp_status <= snoop_pkg::status_hit;
            end else begin
                snoop.resp_status <= snoop_pkg::status_miss;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/snoop_subsys_top.sv
// Snoop subsystem top level with plain ports
// Wires the snoop unit to the L1D array and the store queue

`default_nettype none

module snoop_subsys_top (
    input  wire                      i_clk,
    input  wire                      i_reset_n,
    // Snoop side
    input  wire                      snoop_req_valid,
    output wire                      snoop_req_ready,
    input  wire snoop_pkg::paddr_u   snoop_req_paddr,
    output wire                      snoop_resp_valid,
    output wire snoop_pkg::line_t    snoop_resp_data,
    output wire snoop_pkg::line_be_t snoop_resp_be,
    output wire                      snoop_busy,
    // Core side
    input  wire                      fill_valid,
    input  wire snoop_pkg::paddr_u   fill_paddr,
    input  wire snoop_pkg::line_t    fill_data,
    input  wire                      st_valid,
    output wire                      st_ready,
    input  wire snoop_pkg::paddr_u   st_paddr,
    input  wire snoop_pkg::line_t    st_data,
    input  wire snoop_pkg::line_be_t st_be,
    input  wire                      st_commit
);

    l1d_snoop_if l1d_snoop ();
    stq_snoop_if stq_snoop ();

    snoop_unit snoop_unit_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .req_valid  (snoop_req_valid),
        .req_ready  (snoop_req_ready),
        .req_paddr  (snoop_req_paddr),
        .resp_valid (snoop_resp_valid),
        .resp_data  (snoop_resp_data),
        .resp_be    (snoop_resp_be),
        .busy       (snoop_busy),
        .l1d        (l1d_snoop),
        .stq        (stq_snoop)
    );

    l1d_array l1d_array_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .fill_valid (fill_valid),
        .fill_paddr (fill_paddr),
        .fill_data  (fill_data),
        .snoop      (l1d_snoop)
    );

    store_queue store_queue_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .st_valid   (st_valid),
        .st_ready   (st_ready),
        .st_paddr   (st_paddr),
        .st_data    (st_data),
        .st_be      (st_be),
        .st_commit  (st_commit),
        .snoop      (stq_snoop)
    );

endmodule

`default_nettype wire

// File: logic/store_queue.sv
// Four-entry store queue, circular buffer of line-positioned stores
// Stores enqueue at the tail, a commit retires the head entry
// Snoop lookups overlay matching stores oldest first, answer next cycle

`default_nettype none

`include "snoop_defines.svh"

module store_queue (
    input  wire                      i_clk,
    input  wire                      i_reset_n,
    input  wire                      st_valid,
    output logic                     st_ready,
    input  wire snoop_pkg::paddr_u   st_paddr,
    input  wire snoop_pkg::line_t    st_data,
    input  wire snoop_pkg::line_be_t st_be,
    input  wire                      st_commit,
    stq_snoop_if.queue               snoop
);

    localparam int PTR_W       = $clog2(`SNOOP_STQ_DEPTH);
    localparam int LINE_ADDR_W = `SNOOP_PADDR_W - `SNOOP_OFFSET_W;

    logic [LINE_ADDR_W-1:0] addr_q [`SNOOP_STQ_DEPTH];
    snoop_pkg::line_t       data_q [`SNOOP_STQ_DEPTH];
    snoop_pkg::line_be_t    be_q   [`SNOOP_STQ_DEPTH];

    logic [PTR_W-1:0]       head_q;
    logic [PTR_W-1:0]       tail_q;
    logic [PTR_W:0]         count_q;
    logic                   enq;
    logic                   deq;
    snoop_pkg::line_t       lk_data;
    snoop_pkg::line_be_t    lk_be;

    assign st_ready = count_q != (PTR_W+1)'(`SNOOP_STQ_DEPTH);
    assign enq      = st_valid & st_ready;
    assign deq      = st_commit & (count_q != '0);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            head_q           <= '0;
            tail_q           <= '0;
            count_q          <= '0;
            snoop.resp_valid <= 1'b0;
        end else begin
            snoop.resp_valid <= snoop.req_valid;
            if (enq) begin
                tail_q <= tail_q + 1'b1;
            end
            if (deq) begin
                head_q <= head_q + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (enq) begin
            addr_q[tail_q] <= st_paddr.word[`SNOOP_PADDR_W-1 -: LINE_ADDR_W];
            data_q[tail_q] <= st_data;
            be_q[tail_q]   <= st_be;
        end
        if (snoop.req_valid) begin
            snoop.resp_data <= lk_data;
            snoop.resp_be   <= lk_be;
        end
    end

    // Oldest to youngest, so later stores overwrite earlier bytes
    always_comb begin
        logic [PTR_W-1:0] idx;
        lk_data = '0;
        lk_be   = '0;
        for (int i = 0; i < `SNOOP_STQ_DEPTH; i++) begin
            idx = head_q + PTR_W'(i);
            if (i < count_q &&
                addr_q[idx] == snoop.req_paddr.word[`SNOOP_PADDR_W-1 -: LINE_ADDR_W]) begin
                for (int b = 0; b < `SNOOP_LINE_B; b++) begin
                    if (be_q[idx][b]) begin
                        lk_data[b*8 +: 8] = data_q[idx][b*8 +: 8];
                        lk_be[b]          = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/snoop_assert.sv
// Protocol assertions for the snoop unit, bound into every instance
// Response pulse width, ready against busy, L1D request/response pairing

`default_nettype none

module snoop_assert (
    input wire i_clk,
    input wire i_reset_n,
    input wire req_ready,
    input wire busy,
    input wire resp_valid,
    input wire l1d_req_valid,
    input wire l1d_resp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    resp_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        resp_valid |=> !resp_valid)
        else $error("snoop response valid held for more than one cycle");

    ready_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        req_ready == !busy)
        else $error("snoop request ready does not follow busy");

    // Array answers every request on the next cycle
    l1d_resp_next: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        l1d_req_valid |=> l1d_resp_valid)
        else $error("L1D request without a response in the next cycle");

endmodule

bind snoop_unit snoop_assert snoop_assert_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .req_ready      (req_ready),
    .busy           (busy),
    .resp_valid     (resp_valid),
    .l1d_req_valid  (l1d.req_valid),
    .l1d_resp_valid (l1d.resp_valid)
);

`default_nettype wire

// File: sim/snoop_tb.sv
// Directed testbench for the snoop subsystem top level
// Drives fills, stores, commits and snoops on the falling edge and checks
// every snoop response against a line model of the L1D and store queue

`default_nettype none

`include "snoop_defines.svh"

module snoop_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAG_W      = `SNOOP_PADDR_W - `SNOOP_INDEX_W - `SNOOP_OFFSET_W;
    localparam int LADDR_W    = `SNOOP_PADDR_W - `SNOOP_OFFSET_W;
    localparam int WAIT_LIMIT = 200;        // Cycles before a wait gives up

    logic                i_clk;
    logic                i_reset_n;
    logic                snoop_req_valid;
    snoop_pkg::paddr_u   snoop_req_paddr;
    logic                fill_valid;
    snoop_pkg::paddr_u   fill_paddr;
    snoop_pkg::line_t    fill_data;
    logic                st_valid;
    snoop_pkg::paddr_u   st_paddr;
    snoop_pkg::line_t    st_data;
    snoop_pkg::line_be_t st_be;
    logic                st_commit;
    wire                 snoop_req_ready;
    wire                 snoop_resp_valid;
    snoop_pkg::line_t    snoop_resp_data;
    snoop_pkg::line_be_t snoop_resp_be;
    wire                 snoop_busy;
    wire                 st_ready;

    // Line model of the cache contents with round-robin bits plus the store list
    logic [TAG_W-1:0]    m_tag   [`SNOOP_L1D_SETS][`SNOOP_L1D_WAYS];
    logic                m_valid [`SNOOP_L1D_SETS][`SNOOP_L1D_WAYS];
    snoop_pkg::line_t    m_data  [`SNOOP_L1D_SETS][`SNOOP_L1D_WAYS];
    logic                m_rr    [`SNOOP_L1D_SETS];
    logic [LADDR_W-1:0]  sq_addr [$];       // Oldest first
    snoop_pkg::line_t    sq_data [$];
    snoop_pkg::line_be_t sq_be   [$];

    logic [31:0]         lfsr;
    int                  checks;
    int                  errors;
    int                  timeouts;

    snoop_subsys_top snoop_subsys_top_i (.*);

    always #2 i_clk = ~i_clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
        end
        return r;
    endfunction

    function automatic snoop_pkg::line_t random_line();
        snoop_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = random_bits(32);
        end
        return l;
    endfunction

    // Few tags per set so random fills evict and snoops hit
    function automatic snoop_pkg::paddr_u random_addr();
        snoop_pkg::paddr_u a;
        a.fields.tag    = TAG_W'(random_bits(2));
        a.fields.index  = `SNOOP_INDEX_W'(random_bits(`SNOOP_INDEX_W));
        a.fields.offset = `SNOOP_OFFSET_W'(random_bits(`SNOOP_OFFSET_W));
        return a;
    endfunction

    function automatic void model_fill(input snoop_pkg::paddr_u a, input snoop_pkg::line_t d);
        int way;
        way = -1;
        for (int w = 0; w < `SNOOP_L1D_WAYS; w++) begin
            if (m_valid[a.fields.index][w] && m_tag[a.fields.index][w] == a.fields.tag) begin
                way = w;
            end
        end
        if (way < 0) begin                  // Allocate on the round-robin way
            way = int'(m_rr[a.fields.index]);
            m_rr[a.fields.index] = ~m_rr[a.fields.index];
        end
        m_valid[a.fields.index][way] = 1'b1;
        m_tag[a.fields.index][way]   = a.fields.tag;
        m_data[a.fields.index][way]  = d;
    endfunction

    // Expected merge followed by the invalidate that the snoop causes
    function automatic void model_snoop(input snoop_pkg::paddr_u a,
                                        output snoop_pkg::line_t d,
                                        output snoop_pkg::line_be_t be);
        d  = '0;
        be = '0;
        for (int w = 0; w < `SNOOP_L1D_WAYS; w++) begin
            if (m_valid[a.fields.index][w] && m_tag[a.fields.index][w] == a.fields.tag) begin
                d  = m_data[a.fields.index][w];
                be = '1;
                m_valid[a.fields.index][w] = 1'b0;
            end
        end
        for (int i = 0; i < sq_addr.size(); i++) begin
            if (sq_addr[i] == a.word[`SNOOP_PADDR_W-1 -: LADDR_W]) begin
                for (int b = 0; b < `SNOOP_LINE_B; b++) begin
                    if (sq_be[i][b]) begin
                        d[b*8 +: 8] = sq_data[i][b*8 +: 8];
                        be[b]       = 1'b1;
                    end
                end
            end
        end
    endfunction

    task automatic check_value(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t ns: %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    // ------------------------------------------------------------------------
    // Core side drivers that start and end on a falling edge
    // ------------------------------------------------------------------------
    task automatic do_fill(input snoop_pkg::paddr_u a, input snoop_pkg::line_t d);
        fill_valid = 1'b1;
        fill_paddr = a;
        fill_data  = d;
        @(negedge i_clk);
        fill_valid = 1'b0;
        model_fill(a, d);
    endtask

    task automatic do_store(input snoop_pkg::paddr_u a, input snoop_pkg::line_t d,
                            input snoop_pkg::line_be_t be);
        check_value(st_ready == 1'b1, "st_ready low with room in the store queue");
        st_valid = 1'b1;
        st_paddr = a;
        st_data  = d;
        st_be    = be;
        @(negedge i_clk);
        st_valid = 1'b0;
        sq_addr.push_back(a.word[`SNOOP_PADDR_W-1 -: LADDR_W]);
        sq_data.push_back(d);
        sq_be.push_back(be);
    endtask

    task automatic do_commit();
        st_commit = 1'b1;
        @(negedge i_clk);
        st_commit = 1'b0;
        if (sq_addr.size() > 0) begin
            void'(sq_addr.pop_front());
            void'(sq_data.pop_front());
            void'(sq_be.pop_front());
        end
    endtask

    // Snoop one line and check it against the model
    // exp_lat 0 skips the latency check, fill_hold above 0 keeps an
    // already driven fill active for that many cycles
    task automatic snoop_check(input snoop_pkg::paddr_u a, input int exp_lat,
                               input int fill_hold);
        snoop_pkg::line_t    exp_data;
        snoop_pkg::line_be_t exp_be;
        int                  n;
        n = 0;
        while (!snoop_req_ready && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!snoop_req_ready) begin
            report_timeout("snoop_req_ready");
        end else begin
            model_snoop(a, exp_data, exp_be);
            snoop_req_valid = 1'b1;
            snoop_req_paddr = a;
            @(negedge i_clk);
            snoop_req_valid = 1'b0;
            check_value(snoop_busy && !snoop_req_ready,
                        "snoop_busy low or snoop_req_ready high with a snoop in flight");
            n = 1;
            while (!snoop_resp_valid && n < WAIT_LIMIT) begin
                if (n == fill_hold) begin
                    fill_valid = 1'b0;
                end
                @(negedge i_clk);
                n++;
            end
            if (!snoop_resp_valid) begin
                fill_valid = 1'b0;
                report_timeout("snoop_resp_valid");
            end else begin
                check_value(!fill_valid, "snoop response arrived while fills were active");
                fill_valid = 1'b0;
                check_value(!snoop_busy, "snoop_busy still high with the snoop response");
                check_value(snoop_resp_be == exp_be, $sformatf(
                    "snoop %h mask %h, expected %h", a.word, snoop_resp_be, exp_be));
                check_value(snoop_resp_data == exp_data, $sformatf(
                    "snoop %h data %h, expected %h", a.word, snoop_resp_data, exp_data));
                if (exp_lat > 0) begin
                    check_value(n == exp_lat, $sformatf(
                        "snoop %h latency %0d, expected %0d", a.word, n, exp_lat));
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        check_value(!snoop_resp_valid, "snoop_resp_valid high after reset");
        check_value(!snoop_busy, "snoop_busy high after reset");
        check_value(snoop_req_ready, "snoop_req_ready low after reset");
    endtask

    task automatic test_fill_hit();
        snoop_pkg::paddr_u a;
        a = random_addr();
        do_fill(a, random_line());
        snoop_check(a, 6, 0);               // Full line and then an invalidated miss
        snoop_check(a, 4, 0);
    endtask

    task automatic test_store_merge();
        snoop_pkg::paddr_u a;
        snoop_pkg::paddr_u b;
        a.word = 32'h0000_1520;
        b.word = 32'h0000_2520;             // Same set but another line
        do_fill(a, random_line());
        do_store(a, random_line(), 16'h000F);
        do_store(a, random_line(), 16'h0018);   // Overlaps byte 3
        do_store(b, random_line(), 16'hFFFF);
        snoop_check(a, 6, 0);
        do_commit();
        snoop_check(a, 4, 0);
    endtask

    task automatic test_conflict();
        snoop_pkg::paddr_u a;
        snoop_pkg::paddr_u b;
        a.word = 32'h0000_3650;
        b.word = 32'h0000_3660;             // Next set keeps the snooped line
        do_fill(a, random_line());
        fill_paddr = b;
        fill_data  = random_line();
        fill_valid = 1'b1;
        model_fill(b, fill_data);
        snoop_check(a, 0, 10);
    endtask

    task automatic test_random(input int count);
        logic [1:0]        op;
        snoop_pkg::paddr_u a;
        for (int i = 0; i < count; i++) begin
            op = 2'(random_bits(2));
            a  = random_addr();
            case (op)
                2'd0: do_fill(a, random_line());
                2'd1: begin
                    if (sq_addr.size() < `SNOOP_STQ_DEPTH) begin
                        do_store(a, random_line(), snoop_pkg::line_be_t'(random_bits(16)));
                    end else begin
                        check_value(!st_ready, "st_ready high with a full store queue");
                        do_commit();
                    end
                end
                2'd2: do_commit();
                default: snoop_check(a, 0, 0);
            endcase
        end
    endtask

    initial begin
        i_clk           = 1'b0;
        i_reset_n       = 1'b0;
        snoop_req_valid = 1'b0;
        snoop_req_paddr = '0;
        fill_valid      = 1'b0;
        fill_paddr      = '0;
        fill_data       = '0;
        st_valid        = 1'b0;
        st_paddr        = '0;
        st_data         = '0;
        st_be           = '0;
        st_commit       = 1'b0;
        lfsr            = 32'h8823;
        checks          = 0;
        errors          = 0;
        timeouts        = 0;
        for (int s = 0; s < `SNOOP_L1D_SETS; s++) begin
            m_rr[s] = 1'b0;
            for (int w = 0; w < `SNOOP_L1D_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;
        @(negedge i_clk);

        test_reset();
        snoop_check(random_addr(), 4, 0);   // Empty cache and empty queue
        test_fill_hit();
        test_store_merge();
        test_conflict();
        test_random(60);
        finish_run();
    end

endmodule

`default_nettype wire

// File: snoop/snoop_unit.sv
// Snoop unit. Takes one external snoop at a time, broadcasts the line to
// the L1D array and the store queue, replays conflicted L1D accesses and
// invalidates a hit line. Returns the merged line as a one-cycle pulse.

`default_nettype none

`include "snoop_defines.svh"

module snoop_unit (
    input  wire                      i_clk,
    input  wire                      i_reset_n,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire snoop_pkg::paddr_u   req_paddr,
    output logic                     resp_valid,
    output snoop_pkg::line_t         resp_data,
    output snoop_pkg::line_be_t      resp_be,
    output logic                     busy,
    l1d_snoop_if.unit                l1d,
    stq_snoop_if.unit                stq
);

    localparam int LINE_ADDR_W = `SNOOP_PADDR_W - `SNOOP_OFFSET_W;

    typedef enum logic [1:0] {
        l1d_idle,
        l1d_wait_resp,
        l1d_invalidate
    } l1d_state_t;

    typedef enum logic {
        stq_idle,
        stq_wait_resp
    } stq_state_t;

    l1d_state_t          l1d_state;
    stq_state_t          stq_state;
    logic                l1d_done;
    logic                stq_done;
    logic                accept;
    logic                merge_fire;
    logic                l1d_conflict;
    logic                l1d_hit;
    snoop_pkg::paddr_u   line_paddr;
    snoop_pkg::line_t    l1d_data;
    snoop_pkg::line_be_t l1d_be;
    snoop_pkg::line_t    stq_data;
    snoop_pkg::line_be_t stq_be;
    snoop_pkg::line_t    merged_data;
    snoop_pkg::line_be_t merged_be;

    assign req_ready    = ~busy;
    assign accept       = req_valid & req_ready;
    assign merge_fire   = l1d_done & stq_done;
    assign l1d_conflict = l1d.resp_status == snoop_pkg::status_conflict;
    assign l1d_hit      = l1d.resp_status == snoop_pkg::status_hit;

    // Offset dropped, responders only see the line base
    assign line_paddr.word = {req_paddr.word[`SNOOP_PADDR_W-1 -: LINE_ADDR_W],
                              {`SNOOP_OFFSET_W{1'b0}}};

    // ------------------------------------------------------------------------
    // Control: busy flag and responder state machines
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            busy          <= 1'b0;
            resp_valid    <= 1'b0;
            l1d_state     <= l1d_idle;
            stq_state     <= stq_idle;
            l1d_done      <= 1'b0;
            stq_done      <= 1'b0;
            l1d.req_valid <= 1'b0;
            stq.req_valid <= 1'b0;
        end else begin
            l1d.req_valid <= 1'b0;              // Requests are pulses
            stq.req_valid <= 1'b0;
            resp_valid    <= merge_fire;

            if (accept) begin
                busy <= 1'b1;
            end else if (merge_fire) begin
                busy <= 1'b0;
            end

            case (l1d_state)
                l1d_idle: begin
                    if (accept) begin
                        l1d_state     <= l1d_wait_resp;
                        l1d.req_valid <= 1'b1;
                    end
                end
                l1d_wait_resp: begin
                    if (l1d.resp_valid) begin
                        if (l1d_conflict) begin
                            l1d.req_valid <= 1'b1;  // Replay the read
                        end else if (l1d_hit) begin
                            l1d_state     <= l1d_invalidate;
                            l1d.req_valid <= 1'b1;
                        end else begin
                            l1d_state <= l1d_idle;
                            l1d_done  <= 1'b1;
                        end
                    end
                end
                l1d_invalidate: begin
                    if (l1d.resp_valid) begin
                        if (l1d_conflict) begin
                            l1d.req_valid <= 1'b1;  // Replay the invalidate
                        end else begin
                            l1d_state <= l1d_idle;
                            l1d_done  <= 1'b1;
                        end
                    end
                end
                default: l1d_state <= l1d_idle;
            endcase

            case (stq_state)
                stq_idle: begin
                    if (accept) begin
                        stq_state     <= stq_wait_resp;
                        stq.req_valid <= 1'b1;
                    end
                end
                stq_wait_resp: begin
                    if (stq.resp_valid) begin
                        stq_state <= stq_idle;
                        stq_done  <= 1'b1;
                    end
                end
                default: stq_state <= stq_idle;
            endcase

            if (merge_fire) begin
                l1d_done <= 1'b0;
                stq_done <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Payload: request fields, collected lines, merged result
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (accept) begin
            l1d.req_cmd   <= snoop_pkg::snoop_read;
            l1d.req_paddr <= line_paddr;
            l1d.req_ways  <= '0;
            stq.req_paddr <= line_paddr;
        end
        if (l1d_state == l1d_wait_resp && l1d.resp_valid && !l1d_conflict) begin
            l1d_data <= l1d.resp_data;
            l1d_be   <= {`SNOOP_LINE_B{l1d_hit}};
            if (l1d_hit) begin
                l1d.req_cmd  <= snoop_pkg::snoop_invalid;
                l1d.req_ways <= l1d.resp_ways;
            end
        end
        if (stq_state == stq_wait_resp && stq.resp_valid) begin
            stq_data <= stq.resp_data;
            stq_be   <= stq.resp_be;
        end
        if (merge_fire) begin
            resp_data <= merged_data;
            resp_be   <= merged_be;
        end
    end

    // Store queue bytes first, then cache bytes, zero elsewhere
    always_comb begin
        for (int b = 0; b < `SNOOP_LINE_B; b++) begin
            if (stq_be[b]) begin
                merged_data[b*8 +: 8] = stq_data[b*8 +: 8];
            end else if (l1d_be[b]) begin
                merged_data[b*8 +: 8] = l1d_data[b*8 +: 8];
            end else begin
                merged_data[b*8 +: 8] = 8'h00;
            end
        end
        merged_be = stq_be | l1d_be;
    end

endmodule

`default_nettype wire
